// File: include/eth_tx_consts.svh
`ifndef ETH_TX_CONSTS_SVH
`define ETH_TX_CONSTS_SVH

// frame buffer geometry
`define ETH_BUF_WORDS 512
`define ETH_BUF_AW 9
`define ETH_LEN_W 11

// wishbone word address, top bit selects the register space
`define ETH_WB_AW 10
`define ETH_REG_CTRL 0
`define ETH_REG_STAT 1

`define ETH_PREAMBLE_OCTETS 7
`define ETH_SFD 8'hD5
`define ETH_EOF_CYCLES 4

`endif

// File: source/eth_tx_pkg.sv
package eth_tx_pkg;

  // one buffer word, octets[3] goes out on the line first
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] octets;
  } frame_word_u;

  typedef enum logic [2:0] {
    IDLE,
    PREAMBLE,   // seven 0x55 octets and the start delimiter
    PAYLOAD,
    CRC,
    EOF         // end-of-frame pulse on the line
  } tx_phase_e;

endpackage

// File: source/tx_stream_if.sv
interface tx_stream_if;
  logic        octet_req;    // current octet consumed
  logic [7:0]  octet_data;
  logic        octet_last;   // current octet ends the payload
  logic        crc_bit;
  logic        crc_en;
  logic        crc_clear;
  logic [31:0] crc_value;    // already complemented

  modport serializer (
    output octet_req, crc_bit, crc_en, crc_clear,
    input  octet_data, octet_last, crc_value
  );

  modport fetch (
    input  octet_req,
    output octet_data, octet_last
  );

  modport crc (
    input  crc_bit, crc_en, crc_clear,
    output crc_value
  );
endinterface

// File: source/frame_buffer.sv
`include "eth_tx_consts.svh"

module frame_buffer
  import eth_tx_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`ETH_WB_AW-1:0]  wb_adr,
  input  logic [31:0]            wb_dat_w,
  input  logic [`ETH_BUF_AW-1:0] rd_addr,
  input  logic                   frame_end,
  output logic [31:0]            wb_dat_r,
  output logic                   wb_ack,
  output frame_word_u            rd_data,
  output logic                   start,
  output logic [`ETH_LEN_W-1:0]  send_len
);
  frame_word_u            mem [`ETH_BUF_WORDS];
  logic                   busy;
  logic                   done;
  logic                   req;
  logic                   reg_sel;
  logic                   ctrl_wr;
  logic [`ETH_BUF_AW-1:0] buf_adr;

  assign req     = wb_cyc & wb_stb & ~wb_ack;   // new access, ack not yet given
  assign reg_sel = wb_adr[`ETH_WB_AW-1];
  assign buf_adr = wb_adr[`ETH_BUF_AW-1:0];
  assign ctrl_wr = req & wb_we & reg_sel & (buf_adr == `ETH_REG_CTRL);

  always_ff @(posedge CLK)
  begin
    if (req && wb_we && !reg_sel)
      mem[buf_adr].word <= wb_dat_w;
    if (req)
    begin
      if (!reg_sel)
        wb_dat_r <= mem[buf_adr].word;
      else if (buf_adr == `ETH_REG_STAT)
        wb_dat_r <= {30'd0, done, busy};
      else if (buf_adr == `ETH_REG_CTRL)
        wb_dat_r <= {{(32-`ETH_LEN_W){1'b0}}, send_len};
      else
        wb_dat_r <= 32'd0;
    end
    rd_data <= mem[rd_addr];   // fetch port, one cycle latency
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      wb_ack   <= 1'b0;
      start    <= 1'b0;
      busy     <= 1'b0;
      done     <= 1'b0;
      send_len <= '0;
    end
    else
    begin
      wb_ack <= wb_cyc & wb_stb & ~wb_ack;
      start  <= 1'b0;
      if (frame_end)
      begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (ctrl_wr && !busy)   // frame in flight keeps its length
      begin
        send_len <= wb_dat_w[`ETH_LEN_W-1:0];
        if (wb_dat_w[31])
        begin
          start <= 1'b1;
          busy  <= 1'b1;
          done  <= 1'b0;
        end
      end
    end
  end
endmodule

// File: source/octet_fetch.sv
`include "eth_tx_consts.svh"

module octet_fetch
  import eth_tx_pkg::*;
(
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  input  logic [`ETH_LEN_W-1:0]  send_len,
  input  frame_word_u            rd_data,
  output logic [`ETH_BUF_AW-1:0] rd_addr,
  tx_stream_if.fetch             stream
);
  frame_word_u           cur;        // word holding the current octet
  logic [1:0]            oct_idx;
  logic [1:0]            fill;       // start delayed, primes the first word
  logic [`ETH_LEN_W-1:0] left;       // octets still to hand out
  logic                  word_done;

  assign word_done = stream.octet_req && (oct_idx == 2'd0);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      rd_addr           <= '0;
      oct_idx           <= 2'd3;
      fill              <= 2'b00;
      left              <= '0;
      stream.octet_last <= 1'b0;
    end
    else
    begin
      fill              <= {fill[0], start};
      stream.octet_last <= (left == 1);
      if (start)
      begin
        rd_addr <= '0;
        oct_idx <= 2'd3;   // msb octet of the word goes first
        left    <= send_len;
      end
      else
      begin
        if (fill[0])
          rd_addr <= rd_addr + 1;   // word 0 requested, point at word 1
        if (stream.octet_req)
        begin
          left    <= left - 1;
          oct_idx <= oct_idx - 2'd1;
          if (word_done)
            rd_addr <= rd_addr + 1;
        end
      end
    end
  end

  // rd_data always shows the word after cur once the address settles
  always_ff @(posedge CLK)
  begin
    if (fill[1] || word_done)
      cur <= rd_data;
    stream.octet_data <= cur.octets[oct_idx];
  end
endmodule

// File: source/crc32_unit.sv
module crc32_unit (
  input  logic     CLK,
  input  logic     RST,
  tx_stream_if.crc stream
);
  logic [31:0] crc_q;
  logic        fb;

  assign fb = crc_q[0] ^ stream.crc_bit;

  // result bit 0 is the first bit on the line
  assign stream.crc_value = ~crc_q;

  always_ff @(posedge CLK)
  begin
    if (!RST)
      crc_q <= '1;
    else if (stream.crc_clear)
      crc_q <= '1;
    else if (stream.crc_en)
      crc_q <= {1'b0, crc_q[31:1]} ^ (fb ? 32'hEDB88320 : 32'h0);   // reflected 802.3 poly
  end
endmodule

// File: source/frame_serializer.sv
`include "eth_tx_consts.svh"

module frame_serializer
  import eth_tx_pkg::*;
(
  input  logic            CLK,
  input  logic            RST,
  input  logic            start,
  input  logic            bit_tick,
  output logic            line_bit,
  output logic            line_en,
  output logic            eof,
  output logic            frame_end,
  tx_stream_if.serializer stream
);
  tx_phase_e  phase;
  logic [7:0] shreg;
  logic [2:0] bit_cnt;
  logic [2:0] oct_cnt;       // preamble octet, later crc byte
  logic [2:0] eof_cnt;
  logic       last_loaded;   // octet in shreg ends the payload
  logic       crc_en_q;
  logic       boundary;
  logic       pay_load;
  logic       pay_shift;
  logic [1:0] crc_next;

  assign boundary  = bit_tick && (bit_cnt == 3'd7);
  assign pay_load  = boundary && (((phase == PREAMBLE) && (oct_cnt == `ETH_PREAMBLE_OCTETS)) ||
                                  ((phase == PAYLOAD) && !last_loaded));
  assign pay_shift = bit_tick && !boundary && (phase == PAYLOAD);
  assign crc_next  = oct_cnt[1:0] + 2'd1;

  assign line_bit  = shreg[0];
  assign eof       = (phase == EOF) && (eof_cnt == 3'(`ETH_EOF_CYCLES));
  assign frame_end = (phase == EOF) && (eof_cnt == 3'd0);

  assign stream.octet_req = pay_load;
  assign stream.crc_bit   = shreg[0];   // crc sees each payload bit as it is presented
  assign stream.crc_en    = crc_en_q;
  assign stream.crc_clear = start && (phase == IDLE);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      phase       <= IDLE;
      line_en     <= 1'b0;
      bit_cnt     <= 3'd0;
      oct_cnt     <= 3'd0;
      eof_cnt     <= 3'd0;
      last_loaded <= 1'b0;
      crc_en_q    <= 1'b0;
    end
    else
    begin
      crc_en_q <= pay_load | pay_shift;
      if (bit_tick)
        bit_cnt <= bit_cnt + 3'd1;   // wraps at each octet
      if (pay_load)
        last_loaded <= stream.octet_last;
      case (phase)
        IDLE:
          if (start)
          begin
            phase   <= PREAMBLE;
            line_en <= 1'b1;
            bit_cnt <= 3'd0;
            oct_cnt <= 3'd0;
          end
        PREAMBLE:
          if (boundary)
          begin
            oct_cnt <= oct_cnt + 3'd1;
            if (pay_load)
              phase <= PAYLOAD;
          end
        PAYLOAD:
          if (boundary && last_loaded)
          begin
            phase   <= CRC;
            oct_cnt <= 3'd0;
          end
        CRC:
          if (boundary)
          begin
            oct_cnt <= oct_cnt + 3'd1;
            if (oct_cnt == 3'd3)
            begin
              phase   <= EOF;
              line_en <= 1'b0;
              eof_cnt <= 3'(`ETH_EOF_CYCLES);
            end
          end
        default:   // EOF, wait out the end pulse
          if (eof_cnt == 3'd0)
            phase <= IDLE;
          else
            eof_cnt <= eof_cnt - 3'd1;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if ((phase == IDLE) && start)
      shreg <= 8'h55;   // first preamble octet
    else if (pay_load)
      shreg <= stream.octet_data;
    else if (boundary && (phase == PREAMBLE))
      shreg <= (oct_cnt == `ETH_PREAMBLE_OCTETS - 1) ? `ETH_SFD : 8'h55;
    else if (boundary && (phase == PAYLOAD))
      shreg <= stream.crc_value[7:0];
    else if (boundary && (phase == CRC))
      shreg <= stream.crc_value[{crc_next, 3'b000} +: 8];
    else if (bit_tick)
      shreg <= {1'b0, shreg[7:1]};
  end
endmodule

// File: source/manchester_tx.sv
`include "eth_tx_consts.svh"

module manchester_tx (
  input  logic CLK,
  input  logic RST,
  input  logic line_bit,
  input  logic line_en,
  input  logic eof,
  output logic bit_tick,
  output logic tx_wire,
  output logic tx_active
);
  logic       half;      // set during the second half of a bit
  logic [2:0] eof_cnt;
  logic       pulse;

  assign bit_tick = line_en & half;
  assign pulse    = eof | (eof_cnt != 3'd0);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      half      <= 1'b0;
      eof_cnt   <= 3'd0;
      tx_wire   <= 1'b0;
      tx_active <= 1'b0;
    end
    else
    begin
      half <= line_en & ~half;
      if (eof)
        eof_cnt <= 3'(`ETH_EOF_CYCLES - 1);
      else if (eof_cnt != 3'd0)
        eof_cnt <= eof_cnt - 3'd1;
      if (line_en)
        tx_wire <= half ? line_bit : ~line_bit;   // complement first, then the bit
      else
        tx_wire <= pulse;   // end pulse, then idle low
      tx_active <= line_en | pulse;
    end
  end
endmodule

// File: source/eth_tx_top.sv
`include "eth_tx_consts.svh"

module eth_tx_top
  import eth_tx_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`ETH_WB_AW-1:0] wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,
  output logic                  tx_wire,
  output logic                  tx_active
);
  frame_word_u            rd_data;
  logic [`ETH_BUF_AW-1:0] rd_addr;
  logic                   start;
  logic [`ETH_LEN_W-1:0]  send_len;
  logic                   frame_end;
  logic                   bit_tick;
  logic                   line_bit;
  logic                   line_en;
  logic                   eof;

  tx_stream_if stream ();

  frame_buffer u_buffer (
    .CLK(CLK), .RST(RST),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .rd_addr(rd_addr), .rd_data(rd_data),
    .frame_end(frame_end), .start(start), .send_len(send_len)
  );

  octet_fetch u_fetch (
    .CLK(CLK), .RST(RST), .start(start), .send_len(send_len),
    .rd_data(rd_data), .rd_addr(rd_addr), .stream(stream.fetch)
  );

  crc32_unit u_crc (.CLK(CLK), .RST(RST), .stream(stream.crc));

  frame_serializer u_serializer (
    .CLK(CLK), .RST(RST), .start(start), .bit_tick(bit_tick),
    .line_bit(line_bit), .line_en(line_en), .eof(eof), .frame_end(frame_end),
    .stream(stream.serializer)
  );

  manchester_tx u_line (
    .CLK(CLK), .RST(RST), .line_bit(line_bit), .line_en(line_en), .eof(eof),
    .bit_tick(bit_tick), .tx_wire(tx_wire), .tx_active(tx_active)
  );
endmodule

// File: tests/clock_gen.sv
module clock_gen (
  output logic CLK,
  output logic RST
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;   // 10 ns period
  end

  initial
  begin
    RST = 1'b0;
    repeat (2) @(posedge CLK);
    #1 RST = 1'b1;   // released after two cycles
  end
endmodule

// File: tests/eth_tx_assertions.sv
module eth_tx_assertions
  import eth_tx_pkg::*;
(
  input logic      CLK,
  input logic      RST,
  input logic      wb_ack,
  input logic      bit_tick,
  input logic      tx_wire,
  input logic      tx_active,
  input logic      busy,
  input tx_phase_e phase
);
  timeunit 1ns;
  timeprecision 100ps;

  ack_single: assert property (@(posedge CLK) disable iff (!RST) wb_ack |=> !wb_ack)
    else $error("wb_ack held high for more than one cycle");

  // second half of every bit must differ from the first half
  mid_bit_edge: assert property (@(posedge CLK) disable iff (!RST)
    bit_tick |=> (tx_wire != $past(tx_wire)))
    else $error("no mid-bit transition on tx_wire");

  busy_fall: assert property (@(posedge CLK) disable iff (!RST) $fell(busy) |-> $fell(tx_active))
    else $error("busy cleared apart from the end of tx_active");

  idle_quiet: assert property (@(posedge CLK) disable iff (!RST)
    ((phase == IDLE) && !busy) |-> !tx_active)
    else $error("tx_active high with the serializer idle");
endmodule

bind eth_tx_top eth_tx_assertions u_assertions (
  .CLK(CLK),
  .RST(RST),
  .wb_ack(wb_ack),
  .bit_tick(bit_tick),
  .tx_wire(tx_wire),
  .tx_active(tx_active),
  .busy(u_buffer.busy),
  .phase(u_serializer.phase)
);

// File: tests/eth_tx_tb.sv
`include "eth_tx_consts.svh"

module eth_tx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FRAME_COUNT     = 6;
  localparam int PAYLOAD_TOTAL   = 4 + 1 + 5 + 61 + 8 + 16;
  localparam int WATCHDOG_CYCLES = (FRAME_COUNT * 12 + PAYLOAD_TOTAL) * 16 + 3000;
  localparam int CTRL_ADR        = (1 << (`ETH_WB_AW - 1)) + `ETH_REG_CTRL;
  localparam int STAT_ADR        = (1 << (`ETH_WB_AW - 1)) + `ETH_REG_STAT;
  localparam logic [31:0] START_BIT = 32'h8000_0000;

  logic                  CLK;
  logic                  RST;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`ETH_WB_AW-1:0] wb_adr;
  logic [31:0]           wb_dat_w;
  logic [31:0]           wb_dat_r;
  logic                  wb_ack;
  logic                  tx_wire;
  logic                  tx_active;

  logic [7:0] payload [$];       // octets of the frame under test
  logic [7:0] line_octets [$];   // octets decoded from the line
  int         error_count;
  bit         verdict_shown;

  clock_gen u_clock (.CLK(CLK), .RST(RST));

  eth_tx_top UUT (
    .CLK(CLK), .RST(RST),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .tx_wire(tx_wire), .tx_active(tx_active)
  );

  task automatic abort_run(input string what);
    verdict_shown = 1'b1;
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic mismatch(input string test, input logic [31:0] expected,
                          input logic [31:0] actual);
    error_count++;
    abort_run($sformatf("ERR %s: expected %0h, actual %0h", test, expected, actual));
  endtask

  // one classic cycle with the ack one cycle after the strobe
  task automatic wb_cycle(input bit write, input int adr, input logic [31:0] data,
                          output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge CLK);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = write;
    wb_adr   = adr[`ETH_WB_AW-1:0];
    wb_dat_w = data;
    do
    begin
      @(posedge CLK);
      #1;
      waited++;
    end
    while (!wb_ack && waited < 8);
    assert (wb_ack) else abort_run($sformatf("no wb_ack for access to address %0h", adr));
    assert (waited == 1) else mismatch("wb_ack latency", 1, waited);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input int adr, input logic [31:0] data);
    logic [31:0] ignored;
    wb_cycle(1'b1, adr, data, ignored);
  endtask

  task automatic wb_read(input int adr, output logic [31:0] data);
    wb_cycle(1'b0, adr, 32'd0, data);
  endtask

  // bytewise reflected CRC-32 with the complemented result
  function automatic logic [31:0] ref_crc32(input logic [7:0] data [$]);
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    foreach (data[i])
    begin
      crc = crc ^ {24'd0, data[i]};
      for (int b = 0; b < 8; b++)
        crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
    end
    return ~crc;
  endfunction

  task automatic load_payload(input int n);
    logic [31:0] word;
    payload.delete();
    for (int i = 0; i < n; i++)
      payload.push_back(8'($urandom));
    for (int w = 0; w < (n + 3) / 4; w++)
    begin
      word = $urandom;   // tail of a partial last word stays random
      for (int k = 0; k < 4; k++)
        if (4 * w + k < n)
          word[31 - 8 * k -: 8] = payload[4 * w + k];
      wb_write(w, word);
    end
  endtask

  // samples both halves of each bit at the falling edge
  task automatic decode_frame(input string test, input int n);
    int         waited;
    logic       first;
    logic [7:0] octet;
    waited = 0;
    line_octets.delete();
    @(negedge CLK);
    while (!tx_active)
    begin
      waited++;
      assert (waited <= 4) else abort_run($sformatf("%s: line did not start in time", test));
      @(negedge CLK);
    end
    for (int o = 0; o < 12 + n; o++)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (o != 0 || b != 0)
          @(negedge CLK);
        first = tx_wire;
        @(negedge CLK);
        assert (tx_active && (tx_wire == !first))
          else abort_run($sformatf("%s: bad Manchester bit %0d of octet %0d", test, b, o));
        octet[b] = tx_wire;   // lsb first
      end
      line_octets.push_back(octet);
    end
    for (int c = 0; c < `ETH_EOF_CYCLES; c++)
    begin
      @(negedge CLK);
      assert (tx_wire && tx_active) else abort_run($sformatf("%s: end pulse too short", test));
    end
    @(negedge CLK);
    assert (!tx_wire && !tx_active)
      else abort_run($sformatf("%s: line not idle after the end pulse", test));
  endtask

  task automatic check_frame(input string test);
    logic [7:0]  expected [$];
    logic [31:0] crc;
    crc = ref_crc32(payload);
    for (int i = 0; i < `ETH_PREAMBLE_OCTETS; i++)
      expected.push_back(8'h55);
    expected.push_back(`ETH_SFD);
    foreach (payload[i])
      expected.push_back(payload[i]);
    for (int k = 0; k < 4; k++)
      expected.push_back(crc[8 * k +: 8]);   // fcs goes out low byte first
    foreach (expected[i])
      assert (line_octets[i] == expected[i])
        else mismatch($sformatf("%s octet %0d", test, i), 32'(expected[i]), 32'(line_octets[i]));
  endtask

  task automatic run_frame(input string test, input int n);
    wb_write(CTRL_ADR, START_BIT | n);
    decode_frame(test, n);
    check_frame(test);
  endtask

  task automatic send_frame(input string test, input int n);
    load_payload(n);
    run_frame(test, n);
  endtask

  task automatic reset_state();
    logic [31:0] status;
    assert (!tx_wire && !tx_active) else abort_run("reset_state: line not idle after reset");
    wb_read(STAT_ADR, status);
    assert (status == 32'h0) else mismatch("reset_state status", 32'h0, status);
  endtask

  task automatic buffer_readback();
    int          adrs [8] = '{0, 1, 2, 3, 170, 341, 510, 511};
    logic [31:0] data [8];
    logic [31:0] got;
    foreach (adrs[i])
    begin
      data[i] = $urandom;
      wb_write(adrs[i], data[i]);
    end
    foreach (adrs[i])
    begin
      wb_read(adrs[i], got);
      assert (got == data[i])
        else mismatch($sformatf("buffer_readback word %0d", adrs[i]), data[i], got);
    end
  endtask

  task automatic short_frame();
    logic [7:0] check_str [$];
    check_str = '{8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39};
    assert (ref_crc32(check_str) == 32'hCBF4_3926)
      else mismatch("crc reference", 32'hCBF4_3926, ref_crc32(check_str));
    payload = '{8'hDE, 8'hAD, 8'hBE, 8'hEF};   // msb octet of the word first
    wb_write(0, 32'hDEAD_BEEF);
    run_frame("short_frame", 4);
  endtask

  task automatic random_frames();
    int lengths [3] = '{1, 5, 61};
    foreach (lengths[i])
      send_frame($sformatf("random_frames len %0d", lengths[i]), lengths[i]);
  endtask

  // end pulse timing itself is checked by decode_frame
  task automatic end_of_frame();
    logic [31:0] status;
    send_frame("end_of_frame", 8);
    wb_read(STAT_ADR, status);
    assert (status == 32'h2) else mismatch("end_of_frame status", 32'h2, status);
  endtask

  task automatic start_while_busy();
    logic [31:0] status;
    logic [31:0] length;
    load_payload(16);
    wb_write(CTRL_ADR, START_BIT | 16);
    fork
      decode_frame("start_while_busy", 16);
      begin
        repeat (100) @(posedge CLK);
        wb_write(CTRL_ADR, START_BIT | 3);
        wb_read(STAT_ADR, status);
        assert (status == 32'h1) else mismatch("start_while_busy busy status", 32'h1, status);
      end
    join
    check_frame("start_while_busy");
    wb_read(CTRL_ADR, length);
    assert (length == 16) else mismatch("start_while_busy length", 16, length);
    repeat (40)
    begin
      @(negedge CLK);
      assert (!tx_active) else abort_run("start_while_busy: a second frame followed");
    end
    wb_read(STAT_ADR, status);
    assert (status == 32'h2) else mismatch("start_while_busy done status", 32'h2, status);
  endtask

  initial
  begin
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    error_count   = 0;
    verdict_shown = 1'b0;
    void'($urandom(4943));
    wait (RST === 1'b1);
    reset_state();
    buffer_readback();
    short_frame();
    random_frames();
    end_of_frame();
    start_while_busy();
    verdict_shown = 1'b1;
    if (error_count == 0)
    begin
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      $display("=== FAIL ===");
      $fatal(1, "errors were found");
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    abort_run($sformatf("timeout: run went past %0d clock cycles", WATCHDOG_CYCLES));
  end

  // run stopped before the tests finished
  final
    if (!verdict_shown)
      $display("=== FAIL ===");
endmodule

// File: vlog.f
+incdir+include
source/eth_tx_pkg.sv
source/tx_stream_if.sv
source/frame_buffer.sv
source/octet_fetch.sv
source/crc32_unit.sv
source/frame_serializer.sv
source/manchester_tx.sv
source/eth_tx_top.sv
tests/clock_gen.sv
tests/eth_tx_assertions.sv
tests/eth_tx_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP       = eth_tx_tb
FILELIST  = vlog.f
LOG       = sim.log
FAIL_MSG  = === FAIL ===
PASS_MSG  = === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
